// File: rtl/mips_defs.svh
`ifndef MIPS_DEFS_SVH
`define MIPS_DEFS_SVH

// datapath and register index widths.
`define MIPS_XLEN     32
`define MIPS_REG_AW   5
`define MIPS_RESET_PC 32'h0000_0000

// primary opcodes.
`define MIPS_OP_RTYPE 6'h00
`define MIPS_OP_ADDIU 6'h09
`define MIPS_OP_ANDI  6'h0c
`define MIPS_OP_ORI   6'h0d
`define MIPS_OP_LUI   6'h0f
`define MIPS_OP_LW    6'h23
`define MIPS_OP_SW    6'h2b

// function codes, R format only.
`define MIPS_FN_ADDU  6'h21
`define MIPS_FN_SUBU  6'h23
`define MIPS_FN_AND   6'h24
`define MIPS_FN_OR    6'h25
`define MIPS_FN_XOR   6'h26
`define MIPS_FN_SLT   6'h2a

`endif

// File: rtl/mips_pkg.sv
`default_nettype none
`include "mips_defs.svh"

package mips_pkg;

    typedef struct packed {
        logic [5:0]              opcode;
        logic [`MIPS_REG_AW-1:0] rs;
        logic [`MIPS_REG_AW-1:0] rt;
        logic [`MIPS_REG_AW-1:0] rd;
        logic [4:0]              shamt;
        logic [5:0]              funct;
    } r_fmt_t;

    typedef struct packed {
        logic [5:0]              opcode;
        logic [`MIPS_REG_AW-1:0] rs;
        logic [`MIPS_REG_AW-1:0] rt;
        logic [15:0]             imm;
    } i_fmt_t;

    // one fetched word, seen as register or immediate format.
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
    } instr_u;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_LUI,
        ALU_NOP
    } alu_op_e;

    typedef enum logic [1:0] {
        MEM_NONE,
        MEM_LOAD,
        MEM_STORE
    } mem_op_e;

endpackage

`default_nettype wire

// File: rtl/fetch_stage.sv
`default_nettype none
`include "mips_defs.svh"

module fetch_stage (
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire                   en_pc_i,
    input  wire                   en_ifid_i,
    input  wire                   en_idex_i,
    input  wire mips_pkg::instr_u imem_rdata_i,
    output logic [`MIPS_XLEN-1:0] pc_o,
    output mips_pkg::instr_u      id_instr_o
);

    // one word per enabled cycle.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc_o <= `MIPS_RESET_PC;
        end else if (en_pc_i) begin
            pc_o <= pc_o + 32'd4;
        end
    end

    // the all-zero word is sll r0, r0, 0 and retires as a no-op.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            id_instr_o <= '0;
        end else if (en_ifid_i) begin
            id_instr_o <= imem_rdata_i;
        end else if (en_idex_i) begin
            id_instr_o <= '0;
        end
    end

endmodule

`default_nettype wire

// File: rtl/reg_file.sv
`default_nettype none
`include "mips_defs.svh"

module reg_file (
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire                      we_i,
    input  wire [`MIPS_REG_AW-1:0]   waddr_i,
    input  wire [`MIPS_XLEN-1:0]     wdata_i,
    input  wire [`MIPS_REG_AW-1:0]   raddr_s_i,
    input  wire [`MIPS_REG_AW-1:0]   raddr_t_i,
    output logic [`MIPS_XLEN-1:0]    rdata_s_o,
    output logic [`MIPS_XLEN-1:0]    rdata_t_o
);

    logic [`MIPS_XLEN-1:0] regs_q [1:31];

    // architectural state starts at zero.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs_q[i] <= '0;
            end
        end else if (we_i && waddr_i != '0) begin
            regs_q[waddr_i] <= wdata_i;
        end
    end

    // write-through, so writeback needs no forwarding path of its own.
    function automatic logic [`MIPS_XLEN-1:0] read_port(input logic [`MIPS_REG_AW-1:0] addr);
        if (addr == '0) begin
            return '0;
        end else if (we_i && waddr_i == addr) begin
            return wdata_i;
        end
        return regs_q[addr];
    endfunction

    assign rdata_s_o = read_port(raddr_s_i);
    assign rdata_t_o = read_port(raddr_t_i);

endmodule

`default_nettype wire

// File: rtl/decode_stage.sv
`default_nettype none
`include "mips_defs.svh"

module decode_stage (
    input  wire                    clk,
    input  wire                    rst_n,
    input  wire                    en_idex_i,
    input  wire                    en_exmm_i,
    input  wire mips_pkg::instr_u  instr_i,
    input  wire                    wb_we_i,
    input  wire [`MIPS_REG_AW-1:0] wb_addr_i,
    input  wire [`MIPS_XLEN-1:0]   wb_data_i,
    input  wire                    ex_we_i,
    input  wire                    ex_is_load_i,
    input  wire [`MIPS_REG_AW-1:0] ex_dest_i,
    input  wire [`MIPS_XLEN-1:0]   ex_result_i,
    input  wire                    mm_we_i,
    input  wire [`MIPS_REG_AW-1:0] mm_dest_i,
    input  wire [`MIPS_XLEN-1:0]   mm_result_i,
    output logic [`MIPS_REG_AW-1:0] rs_o,
    output logic [`MIPS_REG_AW-1:0] rt_o,
    output mips_pkg::alu_op_e       ex_alu_op_o,
    output mips_pkg::mem_op_e       ex_mem_op_o,
    output logic                    ex_we_o,
    output logic [`MIPS_REG_AW-1:0] ex_dest_o,
    output logic [`MIPS_XLEN-1:0]   ex_a_o,
    output logic [`MIPS_XLEN-1:0]   ex_b_o,
    output logic [`MIPS_XLEN-1:0]   ex_store_data_o
);

    import mips_pkg::*;

    logic [`MIPS_XLEN-1:0]   rf_s;
    logic [`MIPS_XLEN-1:0]   rf_t;
    logic [`MIPS_XLEN-1:0]   op_a;
    logic [`MIPS_XLEN-1:0]   op_t;
    logic [`MIPS_XLEN-1:0]   imm_ext;
    logic [`MIPS_REG_AW-1:0] dest;
    alu_op_e                 alu_op;
    mem_op_e                 mem_op;
    logic                    we;
    logic                    use_imm;
    logic                    zero_ext;

    assign rs_o = instr_i.i_fmt.rs;
    assign rt_o = instr_i.i_fmt.rt;

    reg_file u_reg_file (
        .clk       (clk),
        .rst_n     (rst_n),
        .we_i      (wb_we_i),
        .waddr_i   (wb_addr_i),
        .wdata_i   (wb_data_i),
        .raddr_s_i (rs_o),
        .raddr_t_i (rt_o),
        .rdata_s_o (rf_s),
        .rdata_t_o (rf_t)
    );

    // ======================================================================
    // instruction decode
    // ======================================================================

    always_comb begin
        alu_op   = ALU_NOP;
        mem_op   = MEM_NONE;
        we       = 1'b0;
        use_imm  = 1'b1;
        zero_ext = 1'b0;
        dest     = instr_i.i_fmt.rt;
        case (instr_i.r_fmt.opcode)
            `MIPS_OP_RTYPE: begin
                use_imm = 1'b0;
                dest    = instr_i.r_fmt.rd;
                we      = 1'b1;
                case (instr_i.r_fmt.funct)
                    `MIPS_FN_ADDU: alu_op = ALU_ADD;
                    `MIPS_FN_SUBU: alu_op = ALU_SUB;
                    `MIPS_FN_AND:  alu_op = ALU_AND;
                    `MIPS_FN_OR:   alu_op = ALU_OR;
                    `MIPS_FN_XOR:  alu_op = ALU_XOR;
                    `MIPS_FN_SLT:  alu_op = ALU_SLT;
                    default:       we     = 1'b0;
                endcase
            end
            `MIPS_OP_ADDIU: begin
                alu_op = ALU_ADD;
                we     = 1'b1;
            end
            `MIPS_OP_ANDI: begin
                alu_op   = ALU_AND;
                we       = 1'b1;
                zero_ext = 1'b1;
            end
            `MIPS_OP_ORI: begin
                alu_op   = ALU_OR;
                we       = 1'b1;
                zero_ext = 1'b1;
            end
            `MIPS_OP_LUI: begin
                alu_op = ALU_LUI;
                we     = 1'b1;
            end
            `MIPS_OP_LW: begin
                alu_op = ALU_ADD;
                mem_op = MEM_LOAD;
                we     = 1'b1;
            end
            `MIPS_OP_SW: begin
                alu_op = ALU_ADD;
                mem_op = MEM_STORE;
            end
            default: ;
        endcase
        // r0 is never a destination downstream.
        if (dest == '0) begin
            we = 1'b0;
        end
    end

    assign imm_ext = zero_ext ? {16'b0, instr_i.i_fmt.imm}
                              : {{16{instr_i.i_fmt.imm[15]}}, instr_i.i_fmt.imm};

    // youngest producer wins; a load in execute is covered by the interlock.
    function automatic logic [`MIPS_XLEN-1:0] fwd(input logic [`MIPS_REG_AW-1:0] idx,
                                                  input logic [`MIPS_XLEN-1:0]   rf_val);
        if (ex_we_i && !ex_is_load_i && ex_dest_i == idx) begin
            return ex_result_i;
        end else if (mm_we_i && mm_dest_i == idx) begin
            return mm_result_i;
        end
        return rf_val;
    endfunction

    assign op_a = fwd(rs_o, rf_s);
    assign op_t = fwd(rt_o, rf_t);

    // ======================================================================
    // ID/EX register
    // ======================================================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_alu_op_o <= ALU_NOP;
            ex_mem_op_o <= MEM_NONE;
            ex_we_o     <= 1'b0;
            ex_dest_o   <= '0;
        end else if (en_idex_i) begin
            ex_alu_op_o <= alu_op;
            ex_mem_op_o <= mem_op;
            ex_we_o     <= we;
            ex_dest_o   <= dest;
        end else if (en_exmm_i) begin
            ex_alu_op_o <= ALU_NOP;
            ex_mem_op_o <= MEM_NONE;
            ex_we_o     <= 1'b0;
            ex_dest_o   <= '0;
        end
    end

    always_ff @(posedge clk) begin
        if (en_idex_i) begin
            ex_a_o          <= op_a;
            ex_b_o          <= use_imm ? imm_ext : op_t;
            ex_store_data_o <= op_t;
        end
    end

    // forwarding also matches r0 and relies on no later stage writing it.
    a_no_r0_write: assert property (@(posedge clk) disable iff (!rst_n)
        !(ex_we_i && ex_dest_i == '0) && !(mm_we_i && mm_dest_i == '0));

endmodule

`default_nettype wire

// File: rtl/execute_stage.sv
`default_nettype none
`include "mips_defs.svh"

module execute_stage (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire                     en_exmm_i,
    input  wire                     en_mmwb_i,
    input  wire mips_pkg::alu_op_e  alu_op_i,
    input  wire mips_pkg::mem_op_e  mem_op_i,
    input  wire                     we_i,
    input  wire [`MIPS_REG_AW-1:0]  dest_i,
    input  wire [`MIPS_XLEN-1:0]    a_i,
    input  wire [`MIPS_XLEN-1:0]    b_i,
    input  wire [`MIPS_XLEN-1:0]    store_data_i,
    output logic [`MIPS_XLEN-1:0]   result_o,
    output mips_pkg::mem_op_e       mm_mem_op_o,
    output logic                    mm_we_o,
    output logic [`MIPS_REG_AW-1:0] mm_dest_o,
    output logic [`MIPS_XLEN-1:0]   mm_result_o,
    output logic [`MIPS_XLEN-1:0]   mm_store_data_o
);

    import mips_pkg::*;

    // also the effective address for lw and sw.
    always_comb begin
        case (alu_op_i)
            ALU_ADD: result_o = a_i + b_i;
            ALU_SUB: result_o = a_i - b_i;
            ALU_AND: result_o = a_i & b_i;
            ALU_OR:  result_o = a_i | b_i;
            ALU_XOR: result_o = a_i ^ b_i;
            ALU_SLT: result_o = {{(`MIPS_XLEN-1){1'b0}}, $signed(a_i) < $signed(b_i)};
            ALU_LUI: result_o = {b_i[15:0], 16'b0};
            default: result_o = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mm_mem_op_o <= MEM_NONE;
            mm_we_o     <= 1'b0;
            mm_dest_o   <= '0;
        end else if (en_exmm_i) begin
            mm_mem_op_o <= mem_op_i;
            mm_we_o     <= we_i;
            mm_dest_o   <= dest_i;
        end else if (en_mmwb_i) begin
            mm_mem_op_o <= MEM_NONE;
            mm_we_o     <= 1'b0;
            mm_dest_o   <= '0;
        end
    end

    always_ff @(posedge clk) begin
        if (en_exmm_i) begin
            mm_result_o     <= result_o;
            mm_store_data_o <= store_data_i;
        end
    end

endmodule

`default_nettype wire

// File: rtl/memory_stage.sv
`default_nettype none
`include "mips_defs.svh"

module memory_stage (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire                     en_mmwb_i,
    input  wire mips_pkg::mem_op_e  mem_op_i,
    input  wire                     we_i,
    input  wire [`MIPS_REG_AW-1:0]  dest_i,
    input  wire [`MIPS_XLEN-1:0]    result_i,
    input  wire [`MIPS_XLEN-1:0]    store_data_i,
    input  wire [`MIPS_XLEN-1:0]    dmem_rdata_i,
    input  wire                     dmem_stall_i,
    output logic                    dmem_req_o,
    output logic                    dmem_we_o,
    output logic [`MIPS_XLEN-1:0]   dmem_addr_o,
    output logic [`MIPS_XLEN-1:0]   dmem_wdata_o,
    output logic                    stall_o,
    output logic [`MIPS_XLEN-1:0]   fwd_result_o,
    output logic                    wb_we_o,
    output logic [`MIPS_REG_AW-1:0] wb_addr_o,
    output logic [`MIPS_XLEN-1:0]   wb_data_o
);

    import mips_pkg::*;

    assign dmem_req_o   = (mem_op_i != MEM_NONE);
    assign dmem_we_o    = (mem_op_i == MEM_STORE);
    assign dmem_addr_o  = {result_i[`MIPS_XLEN-1:2], 2'b00};
    assign dmem_wdata_o = store_data_i;

    // the bus stall only counts against a pending request.
    assign stall_o = dmem_req_o && dmem_stall_i;

    assign fwd_result_o = (mem_op_i == MEM_LOAD) ? dmem_rdata_i : result_i;

    // a held stage leaves a bubble behind, so writeback happens once.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_we_o   <= 1'b0;
            wb_addr_o <= '0;
        end else if (en_mmwb_i) begin
            wb_we_o   <= we_i;
            wb_addr_o <= dest_i;
        end else begin
            wb_we_o   <= 1'b0;
            wb_addr_o <= '0;
        end
    end

    always_ff @(posedge clk) begin
        if (en_mmwb_i) begin
            wb_data_o <= fwd_result_o;
        end
    end

    // holding EX/MM under stall keeps the whole request steady.
    a_req_stable: assert property (@(posedge clk) disable iff (!rst_n)
        stall_o |=> $stable({dmem_req_o, dmem_we_o, dmem_addr_o, dmem_wdata_o}));

endmodule

`default_nettype wire

// File: rtl/pipe_ctrl.sv
`default_nettype none
`include "mips_defs.svh"

module pipe_ctrl (
    input  wire                    rst_n,
    input  wire                    dmem_stall_i,
    input  wire                    ex_is_load_i,
    input  wire [`MIPS_REG_AW-1:0] ex_dest_i,
    input  wire [`MIPS_REG_AW-1:0] id_rs_i,
    input  wire [`MIPS_REG_AW-1:0] id_rt_i,
    output logic                   en_pc_o,
    output logic                   en_ifid_o,
    output logic                   en_idex_o,
    output logic                   en_exmm_o,
    output logic                   en_mmwb_o
);

    logic       load_use;
    logic [4:0] en;

    // load data only exists one stage later, so decode must wait a cycle.
    assign load_use = ex_is_load_i && (ex_dest_i != '0) &&
                      (ex_dest_i == id_rs_i || ex_dest_i == id_rt_i);

    // order is pc, if/id, id/ex, ex/mm, mm/wb.
    always_comb begin
        if (!rst_n) begin
            en = 5'b11111;
        end else if (dmem_stall_i) begin
            en = 5'b00000;
        end else if (load_use) begin
            en = 5'b00011;
        end else begin
            en = 5'b11111;
        end
    end

    assign {en_pc_o, en_ifid_o, en_idex_o, en_exmm_o, en_mmwb_o} = en;

endmodule

`default_nettype wire

// File: rtl/mips_core_top.sv
`default_nettype none
`include "mips_defs.svh"

module mips_core_top (
    input  wire                   clk,
    input  wire                   rst_n,
    output logic [`MIPS_XLEN-1:0] imem_addr_o,
    input  wire [`MIPS_XLEN-1:0]  imem_rdata_i,
    output logic                  dmem_req_o,
    output logic                  dmem_we_o,
    output logic [`MIPS_XLEN-1:0] dmem_addr_o,
    output logic [`MIPS_XLEN-1:0] dmem_wdata_o,
    input  wire [`MIPS_XLEN-1:0]  dmem_rdata_i,
    input  wire                   dmem_stall_i
);

    import mips_pkg::*;

    logic                    en_pc;
    logic                    en_ifid;
    logic                    en_idex;
    logic                    en_exmm;
    logic                    en_mmwb;
    instr_u                  id_instr;
    logic [`MIPS_REG_AW-1:0] id_rs;
    logic [`MIPS_REG_AW-1:0] id_rt;
    alu_op_e                 ex_alu_op;
    mem_op_e                 ex_mem_op;
    logic                    ex_we;
    logic                    ex_is_load;
    logic [`MIPS_REG_AW-1:0] ex_dest;
    logic [`MIPS_XLEN-1:0]   ex_a;
    logic [`MIPS_XLEN-1:0]   ex_b;
    logic [`MIPS_XLEN-1:0]   ex_store_data;
    logic [`MIPS_XLEN-1:0]   ex_result;
    mem_op_e                 mm_mem_op;
    logic                    mm_we;
    logic [`MIPS_REG_AW-1:0] mm_dest;
    logic [`MIPS_XLEN-1:0]   mm_result;
    logic [`MIPS_XLEN-1:0]   mm_store_data;
    logic [`MIPS_XLEN-1:0]   mm_fwd_result;
    logic                    dmem_stall;
    logic                    wb_we;
    logic [`MIPS_REG_AW-1:0] wb_addr;
    logic [`MIPS_XLEN-1:0]   wb_data;

    assign ex_is_load = (ex_mem_op == MEM_LOAD);

    // ======================================================================
    // pipeline stages
    // ======================================================================

    fetch_stage u_fetch (
        .clk          (clk),
        .rst_n        (rst_n),
        .en_pc_i      (en_pc),
        .en_ifid_i    (en_ifid),
        .en_idex_i    (en_idex),
        .imem_rdata_i (imem_rdata_i),
        .pc_o         (imem_addr_o),
        .id_instr_o   (id_instr)
    );

    decode_stage u_decode (
        .clk             (clk),
        .rst_n           (rst_n),
        .en_idex_i       (en_idex),
        .en_exmm_i       (en_exmm),
        .instr_i         (id_instr),
        .wb_we_i         (wb_we),
        .wb_addr_i       (wb_addr),
        .wb_data_i       (wb_data),
        .ex_we_i         (ex_we),
        .ex_is_load_i    (ex_is_load),
        .ex_dest_i       (ex_dest),
        .ex_result_i     (ex_result),
        .mm_we_i         (mm_we),
        .mm_dest_i       (mm_dest),
        .mm_result_i     (mm_fwd_result),
        .rs_o            (id_rs),
        .rt_o            (id_rt),
        .ex_alu_op_o     (ex_alu_op),
        .ex_mem_op_o     (ex_mem_op),
        .ex_we_o         (ex_we),
        .ex_dest_o       (ex_dest),
        .ex_a_o          (ex_a),
        .ex_b_o          (ex_b),
        .ex_store_data_o (ex_store_data)
    );

    execute_stage u_execute (
        .clk             (clk),
        .rst_n           (rst_n),
        .en_exmm_i       (en_exmm),
        .en_mmwb_i       (en_mmwb),
        .alu_op_i        (ex_alu_op),
        .mem_op_i        (ex_mem_op),
        .we_i            (ex_we),
        .dest_i          (ex_dest),
        .a_i             (ex_a),
        .b_i             (ex_b),
        .store_data_i    (ex_store_data),
        .result_o        (ex_result),
        .mm_mem_op_o     (mm_mem_op),
        .mm_we_o         (mm_we),
        .mm_dest_o       (mm_dest),
        .mm_result_o     (mm_result),
        .mm_store_data_o (mm_store_data)
    );

    memory_stage u_memory (
        .clk          (clk),
        .rst_n        (rst_n),
        .en_mmwb_i    (en_mmwb),
        .mem_op_i     (mm_mem_op),
        .we_i         (mm_we),
        .dest_i       (mm_dest),
        .result_i     (mm_result),
        .store_data_i (mm_store_data),
        .dmem_rdata_i (dmem_rdata_i),
        .dmem_stall_i (dmem_stall_i),
        .dmem_req_o   (dmem_req_o),
        .dmem_we_o    (dmem_we_o),
        .dmem_addr_o  (dmem_addr_o),
        .dmem_wdata_o (dmem_wdata_o),
        .stall_o      (dmem_stall),
        .fwd_result_o (mm_fwd_result),
        .wb_we_o      (wb_we),
        .wb_addr_o    (wb_addr),
        .wb_data_o    (wb_data)
    );

    // ======================================================================
    // stage enables
    // ======================================================================

    pipe_ctrl u_pipe_ctrl (
        .rst_n        (rst_n),
        .dmem_stall_i (dmem_stall),
        .ex_is_load_i (ex_is_load),
        .ex_dest_i    (ex_dest),
        .id_rs_i      (id_rs),
        .id_rt_i      (id_rt),
        .en_pc_o      (en_pc),
        .en_ifid_o    (en_ifid),
        .en_idex_o    (en_idex),
        .en_exmm_o    (en_exmm),
        .en_mmwb_o    (en_mmwb)
    );

endmodule

`default_nettype wire

// File: verification/tb_clk_gen.sv
`default_nettype none

module tb_clk_gen (
    output logic clk_o,
    output logic rst_n_o
);

    timeunit 1ns;
    timeprecision 100ps;

    // reset spans three rising edges, released just after the third.
    initial begin
        clk_o   = 1'b0;
        rst_n_o = 1'b0;
        repeat (3) @(posedge clk_o);
        #1;
        rst_n_o = 1'b1;
    end

    always #5 clk_o = ~clk_o;

endmodule

`default_nettype wire

// File: verification/mips_core_tb.sv
`default_nettype none
`include "mips_defs.svh"

module mips_core_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int PROG_LEN  = 200;
    localparam int TAIL_LEN  = 7;
    localparam int ROM_WORDS = 256;
    localparam int TIMEOUT   = (PROG_LEN + TAIL_LEN + 10) * 4;

    logic        clk;
    logic        rst_n;
    logic [31:0] imem_addr;
    logic [31:0] imem_rdata;
    logic        dmem_req;
    logic        dmem_we;
    logic [31:0] dmem_addr;
    logic [31:0] dmem_wdata;
    logic [31:0] dmem_rdata;
    logic        dmem_stall;

    logic [31:0] rom [0:ROM_WORDS-1];
    logic [31:0] dmem [0:31];
    logic [31:0] model_mem [0:31];
    logic [31:0] model_regs [0:31];
    logic [63:0] exp_q [$];
    logic [63:0] exp_store;
    int          exp_total;
    int          stores_seen;
    int          err_count;
    int          cycles;
    int unsigned seed;

    tb_clk_gen u_clk_gen (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    mips_core_top dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .imem_addr_o  (imem_addr),
        .imem_rdata_i (imem_rdata),
        .dmem_req_o   (dmem_req),
        .dmem_we_o    (dmem_we),
        .dmem_addr_o  (dmem_addr),
        .dmem_wdata_o (dmem_wdata),
        .dmem_rdata_i (dmem_rdata),
        .dmem_stall_i (dmem_stall)
    );

    // past the end of the program the ROM reads as no-ops.
    assign imem_rdata = (imem_addr < ROM_WORDS * 4) ? rom[imem_addr[9:2]] : 32'h0;
    assign dmem_rdata = dmem[dmem_addr[6:2]];

    function automatic logic [31:0] fill_word(input int idx);
        return 32'hd00d_0000 + 32'(idx * 4);
    endfunction

    // ======================================================================
    // program generation and ISA model
    // ======================================================================

    task automatic build_program();
        int          sel;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [15:0] imm;
        logic [15:0] off;
        for (int i = 0; i < ROM_WORDS; i++) begin
            rom[i] = 32'h0;
        end
        for (int i = 0; i < PROG_LEN; i++) begin
            rs  = 5'($urandom % 8);
            rt  = 5'($urandom % 8);
            rd  = 5'($urandom % 8);
            imm = 16'($urandom);
            off = 16'(($urandom % 16) * 4);
            sel = $urandom % 20;
            if (sel == 0) begin
                rom[i] = {6'h30 | 6'($urandom % 8), 26'($urandom)};
            end else begin
                case ($urandom % 12)
                    0:  rom[i] = {`MIPS_OP_RTYPE, rs, rt, rd, 5'd0, `MIPS_FN_ADDU};
                    1:  rom[i] = {`MIPS_OP_RTYPE, rs, rt, rd, 5'd0, `MIPS_FN_SUBU};
                    2:  rom[i] = {`MIPS_OP_RTYPE, rs, rt, rd, 5'd0, `MIPS_FN_AND};
                    3:  rom[i] = {`MIPS_OP_RTYPE, rs, rt, rd, 5'd0, `MIPS_FN_OR};
                    4:  rom[i] = {`MIPS_OP_RTYPE, rs, rt, rd, 5'd0, `MIPS_FN_XOR};
                    5:  rom[i] = {`MIPS_OP_RTYPE, rs, rt, rd, 5'd0, `MIPS_FN_SLT};
                    6:  rom[i] = {`MIPS_OP_ADDIU, rs, rt, imm};
                    7:  rom[i] = {`MIPS_OP_ANDI, rs, rt, imm};
                    8:  rom[i] = {`MIPS_OP_ORI, rs, rt, imm};
                    9:  rom[i] = {`MIPS_OP_LUI, 5'd0, rt, imm};
                    10: rom[i] = {`MIPS_OP_LW, 5'd0, rt, off};
                    default: rom[i] = {`MIPS_OP_SW, 5'd0, rt, off};
                endcase
            end
        end
        // dump r1..r7 above the random data window.
        for (int r = 1; r <= TAIL_LEN; r++) begin
            rom[PROG_LEN + r - 1] = {`MIPS_OP_SW, 5'd0, 5'(r), 16'(64 + 4 * (r - 1))};
        end
    endtask

    task automatic write_reg(input logic [4:0] idx, input logic [31:0] val);
        if (idx != 5'd0) begin
            model_regs[idx] = val;
        end
    endtask

    task automatic run_model();
        logic [31:0] w;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] simm;
        logic [31:0] addr;
        for (int i = 0; i < PROG_LEN + TAIL_LEN; i++) begin
            w    = rom[i];
            a    = model_regs[w[25:21]];
            b    = model_regs[w[20:16]];
            simm = {{16{w[15]}}, w[15:0]};
            addr = a + simm;
            case (w[31:26])
                `MIPS_OP_RTYPE: begin
                    case (w[5:0])
                        `MIPS_FN_ADDU: write_reg(w[15:11], a + b);
                        `MIPS_FN_SUBU: write_reg(w[15:11], a - b);
                        `MIPS_FN_AND:  write_reg(w[15:11], a & b);
                        `MIPS_FN_OR:   write_reg(w[15:11], a | b);
                        `MIPS_FN_XOR:  write_reg(w[15:11], a ^ b);
                        `MIPS_FN_SLT:  write_reg(w[15:11], {31'b0, $signed(a) < $signed(b)});
                        default: ;
                    endcase
                end
                `MIPS_OP_ADDIU: write_reg(w[20:16], addr);
                `MIPS_OP_ANDI:  write_reg(w[20:16], a & {16'b0, w[15:0]});
                `MIPS_OP_ORI:   write_reg(w[20:16], a | {16'b0, w[15:0]});
                `MIPS_OP_LUI:   write_reg(w[20:16], {w[15:0], 16'b0});
                `MIPS_OP_LW:    write_reg(w[20:16], model_mem[addr[6:2]]);
                `MIPS_OP_SW: begin
                    model_mem[addr[6:2]] = b;
                    exp_q.push_back({addr, b});
                    exp_total++;
                end
                default: ;
            endcase
        end
    endtask

    // ======================================================================
    // bus models and checks
    // ======================================================================

    always begin
        @(posedge clk);
        #1;
        dmem_stall = (($urandom % 100) < 30);
    end

    // outputs are settled by the falling edge; a store completes in this cycle.
    always @(negedge clk) begin
        if (rst_n && dmem_req && !dmem_stall && dmem_we) begin
            assert (exp_q.size() != 0)
            else begin
                err_count++;
                $display("unexpected store to %h after all expected stores were seen",
                         dmem_addr);
            end
            if (exp_q.size() != 0) begin
                exp_store = exp_q.pop_front();
                assert (dmem_addr == exp_store[63:32] && dmem_wdata == exp_store[31:0])
                else begin
                    err_count++;
                    $display("Error at %0t ns: store %0d expected %h <= %h, got %h <= %h",
                             $time, stores_seen, exp_store[63:32], exp_store[31:0],
                             dmem_addr, dmem_wdata);
                end
                stores_seen++;
            end
            dmem[dmem_addr[6:2]] = dmem_wdata;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT) begin
            $display("timeout: %0d of %0d stores seen after %0d cycles",
                     stores_seen, exp_total, TIMEOUT);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    initial begin
        seed        = $urandom(32'h9e68);
        dmem_stall  = 1'b0;
        exp_total   = 0;
        stores_seen = 0;
        err_count   = 0;
        cycles      = 0;
        for (int i = 0; i < 32; i++) begin
            dmem[i]       = fill_word(i);
            model_mem[i]  = fill_word(i);
            model_regs[i] = 32'h0;
        end
        build_program();
        run_model();

        @(negedge clk);
        assert (imem_addr == 32'h0 && !dmem_req && !dmem_we)
        else begin
            err_count++;
            $display("Error at %0t ns: reset state pc %h req %b we %b",
                     $time, imem_addr, dmem_req, dmem_we);
        end

        while (stores_seen < exp_total) begin
            @(posedge clk);
        end
        // a few more cycles so that any trailing store would show up.
        repeat (10) @(posedge clk);

        for (int r = 1; r <= TAIL_LEN; r++) begin
            assert (dmem[15 + r] == model_regs[r])
            else begin
                err_count++;
                $display("Error at %0t ns: r%0d dumped %h, model %h",
                         $time, r, dmem[15 + r], model_regs[r]);
            end
        end

        $display("stores checked: %0d of %0d, errors: %0d", stores_seen, exp_total, err_count);
        if (err_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+rtl
rtl/mips_pkg.sv
rtl/fetch_stage.sv
rtl/reg_file.sv
rtl/decode_stage.sv
rtl/execute_stage.sv
rtl/memory_stage.sv
rtl/pipe_ctrl.sv
rtl/mips_core_top.sv
verification/tb_clk_gen.sv
verification/mips_core_tb.sv

// File: Bender.yml
package:
  name: mips_core

export_include_dirs:
  - rtl

sources:
  - rtl/mips_pkg.sv
  - rtl/fetch_stage.sv
  - rtl/reg_file.sv
  - rtl/decode_stage.sv
  - rtl/execute_stage.sv
  - rtl/memory_stage.sv
  - rtl/pipe_ctrl.sv
  - rtl/mips_core_top.sv
  - target: test
    files:
      - verification/tb_clk_gen.sv
      - verification/mips_core_tb.sv
